/* pc_consts.svh */
/*
 * fixed widths of the pc system bus and the i/o port groups
 * a group is xa[7:5] of a port below 0x100, groups 6 and 7 unused
 */
`ifndef PC_CONSTS_SVH
`define PC_CONSTS_SVH

// bus widths
`define PC_ADDR_W      20
`define PC_IO_ADDR_W   10
`define PC_DATA_W      8

// dma page register file
`define PC_PAGE_W      4
`define PC_PAGE_N      4
`define PC_DMA_OFS_W   16

// top 64k region, holds the eight rom chips
`define PC_ROM_REGION  4'hF

// port groups, 32 ports each
`define PC_GRP_DMA     3'd0   // 8237
`define PC_GRP_INTR    3'd1   // 8259
`define PC_GRP_TIMER   3'd2   // 8253
`define PC_GRP_PPI     3'd3   // 8255
`define PC_GRP_PAGE    3'd4   // 0x80, page registers
`define PC_GRP_NMI     3'd5   // 0xa0, nmi mask

`endif

/* pc_bus_pkg.sv */
/*
 * bus-side types: one i/o cycle, one memory cycle and the two
 * decodings of a 20-bit system address (dma page/offset, rom map)
 */
`include "pc_consts.svh"

package pc_bus_pkg;

   typedef struct packed {
      logic                     ior_n;
      logic                     iow_n;
      logic [`PC_IO_ADDR_W-1:0] xa;
      logic [`PC_DATA_W-1:0]    xd;
   } io_bus_t;

   typedef struct packed {
      logic                  memr_n;
      logic                  memw_n;
      logic [`PC_ADDR_W-1:0] a;
   } mem_bus_t;

   // address as the dma path builds it
   typedef struct packed {
      logic [`PC_PAGE_W-1:0]    page;
      logic [`PC_DMA_OFS_W-1:0] offset;
   } dma_addr_t;

   // address as the memory decode reads it
   typedef struct packed {
      logic [3:0]  region;       // 64k region
      logic [2:0]  rom_chip;     // 8k chip within the rom region
      logic [12:0] rom_offset;
   } mem_addr_t;

   typedef union packed {
      dma_addr_t dma;
      mem_addr_t mem;
   } bus_addr_u;

endpackage

/* pc_decode_pkg.sv */
/*
 * decode-side types: active-low chip selects and the one-cycle
 * write requests handed from the port decoder to the registers
 */
`include "pc_consts.svh"

package pc_decode_pkg;

   typedef struct packed {
      logic dma_cs_n;
      logic intr_cs_n;
      logic tc_cs_n;
      logic ppi_cs_n;
   } io_sel_t;

   typedef struct packed {
      logic [7:0] rom_cs_n;      // one per 8k rom chip
      logic [3:0] ram_bank_n;    // one per 64k bank
   } mem_sel_t;

   typedef struct packed {
      logic                  en;
      logic [1:0]            idx;
      logic [`PC_PAGE_W-1:0] data;
   } page_wr_t;

   typedef struct packed {
      logic en;
      logic mask;                // xd[7] of the write
   } nmi_wr_t;

endpackage

/* io_port_decoder.sv */
/*
 * i/o decode of ports 0x000-0x0ff into 32-port groups
 * only decodes while the cpu owns the bus (aen low)
 * all outputs registered, one cycle behind the sampled cycle
 */
`timescale 1ns/10ps
`include "pc_consts.svh"

module io_port_decoder (
   input  logic                    clk,
   input  logic                    reset_n,
   input  pc_bus_pkg::io_bus_t     io_cycle_i,
   input  logic                    aen_i,
   output pc_decode_pkg::io_sel_t  io_sel_o,
   output pc_decode_pkg::page_wr_t page_wr_o,
   output pc_decode_pkg::nmi_wr_t  nmi_wr_o
);

   logic       io_hit;      // cpu cycle, port below 0x100
   logic [2:0] grp;
   logic       io_strobe;
   logic       io_write;

   pc_decode_pkg::io_sel_t  sel_nxt;
   pc_decode_pkg::page_wr_t page_nxt;
   pc_decode_pkg::nmi_wr_t  nmi_nxt;

   assign io_hit    = !aen_i && (io_cycle_i.xa[9:8] == 2'b00);
   assign grp       = io_cycle_i.xa[7:5];
   assign io_strobe = !io_cycle_i.ior_n || !io_cycle_i.iow_n;
   assign io_write  = io_hit && !io_cycle_i.iow_n;

   // device chip selects
   always_comb begin
      sel_nxt = '1;
      if (io_hit && io_strobe) begin
         case (grp)
            `PC_GRP_DMA:   sel_nxt.dma_cs_n  = 1'b0;
            `PC_GRP_INTR:  sel_nxt.intr_cs_n = 1'b0;
            `PC_GRP_TIMER: sel_nxt.tc_cs_n   = 1'b0;
            `PC_GRP_PPI:   sel_nxt.ppi_cs_n  = 1'b0;
            default:       sel_nxt           = '1;  // page, nmi, unused
         endcase
      end
   end

   // write requests, one per cycle with iow_n low
   always_comb begin
      page_nxt.en   = io_write && (grp == `PC_GRP_PAGE);
      page_nxt.idx  = io_cycle_i.xa[1:0];      // 0x80 lands on word 0, never read
      page_nxt.data = io_cycle_i.xd[`PC_PAGE_W-1:0];

      nmi_nxt.en    = io_write && (grp == `PC_GRP_NMI);
      nmi_nxt.mask  = io_cycle_i.xd[`PC_DATA_W-1];
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         io_sel_o  <= '1;
         page_wr_o <= '0;
         nmi_wr_o  <= '0;
      end else begin
         io_sel_o  <= sel_nxt;
         page_wr_o <= page_nxt;
         nmi_wr_o  <= nmi_nxt;
      end
   end

endmodule

/* dma_page_file.sv */
/*
 * four-word dma page register file, written from ports 0x80-0x83
 * read side follows the pc wiring: {dack2_n, dack3_n} picks the word,
 * so ch2 reads 0x81, ch3 reads 0x82, ch1 or idle reads 0x83
 * dack0_n and dack1_n do not take part in the read index
 */
`timescale 1ns/10ps
`include "pc_consts.svh"

module dma_page_file (
   input  logic                    clk,
   input  logic                    reset_n,
   input  pc_decode_pkg::page_wr_t page_wr_i,
   input  logic [3:0]              dack_n_i,
   output logic [`PC_PAGE_W-1:0]   page_o
);

   logic [`PC_PAGE_W-1:0] pages [`PC_PAGE_N];
   logic [1:0]            rd_idx;

   // write port
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         for (int i = 0; i < `PC_PAGE_N; i++) begin
            pages[i] <= '0;
         end
      end else if (page_wr_i.en) begin
         pages[page_wr_i.idx] <= page_wr_i.data;
      end
   end

   // read port, same address pins as the ls670 ra/rb
   assign rd_idx = {dack_n_i[2], dack_n_i[3]};
   assign page_o = pages[rd_idx];     // combinational into memory_select

endmodule

/* memory_select.sv */
/*
 * system address mux and memory decode, both registered
 * during dma (aen high) the address is page : offset, else the cpu address
 * rom chips cover region 0xf, ram banks cover regions 0-3
 * the decode always works on the muxed address
 */
`timescale 1ns/10ps
`include "pc_consts.svh"

module memory_select (
   input  logic                    clk,
   input  logic                    reset_n,
   input  pc_bus_pkg::mem_bus_t    mem_cycle_i,
   input  logic                    aen_i,
   input  logic [`PC_DMA_OFS_W-1:0] dma_offset_i,
   input  logic [`PC_PAGE_W-1:0]   page_i,
   output logic [`PC_ADDR_W-1:0]   bus_addr_o,
   output pc_decode_pkg::mem_sel_t mem_sel_o
);

   pc_bus_pkg::bus_addr_u  addr_nxt;
   pc_decode_pkg::mem_sel_t sel_nxt;
   logic                    mem_strobe;

   assign mem_strobe = !mem_cycle_i.memr_n || !mem_cycle_i.memw_n;

   // address composition
   always_comb begin
      if (aen_i) begin
         addr_nxt.dma.page   = page_i;
         addr_nxt.dma.offset = dma_offset_i;
      end else begin
         addr_nxt = mem_cycle_i.a;
      end
   end

   // rom and ram decode
   always_comb begin
      sel_nxt = '1;

      // rom answers reads only
      if (addr_nxt.mem.region == `PC_ROM_REGION && !mem_cycle_i.memr_n) begin
         sel_nxt.rom_cs_n[addr_nxt.mem.rom_chip] = 1'b0;
      end

      // low 256k, one bank per 64k
      if (addr_nxt.mem.region[3:2] == 2'b00 && mem_strobe) begin
         sel_nxt.ram_bank_n[addr_nxt.mem.region[1:0]] = 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         bus_addr_o <= '0;
         mem_sel_o  <= '1;
      end else begin
         bus_addr_o <= addr_nxt;
         mem_sel_o  <= sel_nxt;
      end
   end

endmodule

/* nmi_control.sv */
/*
 * nmi mask register (port 0xa0 bit 7) and i/o channel check latch
 * the latch holds only while enable_io_ck_n is low; raising it clears
 * nmi_o = mask & latch, no parity source in this design
 */
`timescale 1ns/10ps

module nmi_control (
   input  logic                   clk,
   input  logic                   reset_n,
   input  pc_decode_pkg::nmi_wr_t nmi_wr_i,
   input  logic                   io_ch_ck_n_i,
   input  logic                   enable_io_ck_n_i,
   output logic                   nmi_o
);

   logic mask_q;     // allow nmi
   logic chk_q;      // i/o channel check seen

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         mask_q <= 1'b0;
      end else if (nmi_wr_i.en) begin
         mask_q <= nmi_wr_i.mask;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         chk_q <= 1'b0;
      end else if (!io_ch_ck_n_i) begin
         chk_q <= 1'b1;
      end else if (enable_io_ck_n_i) begin
         chk_q <= 1'b0;            // check disabled by the ppi
      end
   end

   assign nmi_o = mask_q && chk_q;

endmodule

/* pc_glue_top.sv */
/*
 * system-board glue of an 8088 pc, single clock domain
 * strobes are plain active-low levels sampled at clk, no handshake
 * selects and bus address lag their bus cycle by one clock
 */
`timescale 1ns/10ps
`include "pc_consts.svh"

module pc_glue_top (
   input  logic                     clk,
   input  logic                     reset_n,
   input  pc_bus_pkg::io_bus_t      io_cycle_i,
   input  pc_bus_pkg::mem_bus_t     mem_cycle_i,
   input  logic                     aen_i,
   input  logic [`PC_DMA_OFS_W-1:0] dma_offset_i,
   input  logic [3:0]               dack_n_i,
   input  logic                     io_ch_ck_n_i,
   input  logic                     enable_io_ck_n_i,
   output pc_decode_pkg::io_sel_t   io_sel_o,
   output pc_decode_pkg::mem_sel_t  mem_sel_o,
   output logic [`PC_ADDR_W-1:0]    bus_addr_o,
   output logic                     nmi_o
);

   pc_decode_pkg::page_wr_t page_wr;    // decoder -> page file
   pc_decode_pkg::nmi_wr_t  nmi_wr;     // decoder -> nmi
   logic [`PC_PAGE_W-1:0]   page;       // page file -> address mux

   io_port_decoder i_io_dec (
      .clk        (clk),
      .reset_n    (reset_n),
      .io_cycle_i (io_cycle_i),
      .aen_i      (aen_i),
      .io_sel_o   (io_sel_o),
      .page_wr_o  (page_wr),
      .nmi_wr_o   (nmi_wr)
   );

   dma_page_file i_page_file (
      .clk       (clk),
      .reset_n   (reset_n),
      .page_wr_i (page_wr),
      .dack_n_i  (dack_n_i),
      .page_o    (page)
   );

   memory_select i_mem_sel (
      .clk          (clk),
      .reset_n      (reset_n),
      .mem_cycle_i  (mem_cycle_i),
      .aen_i        (aen_i),
      .dma_offset_i (dma_offset_i),
      .page_i       (page),
      .bus_addr_o   (bus_addr_o),
      .mem_sel_o    (mem_sel_o)
   );

   nmi_control i_nmi (
      .clk              (clk),
      .reset_n          (reset_n),
      .nmi_wr_i         (nmi_wr),
      .io_ch_ck_n_i     (io_ch_ck_n_i),
      .enable_io_ck_n_i (enable_io_ck_n_i),
      .nmi_o            (nmi_o)
   );

endmodule

/* pc_glue_props.sv */
/*
 * output properties of the board glue, bound into pc_glue_top
 * assumes one device per port group and disjoint rom and ram regions
 */
`timescale 1ns/10ps

module pc_glue_props (
   input logic                    clk_i,
   input logic                    reset_n_i,
   input pc_decode_pkg::io_sel_t  io_sel_i,
   input pc_decode_pkg::mem_sel_t mem_sel_i,
   input logic                    nmi_i
);

   int fail_cnt = 0;

   one_io_sel: assert property (@(posedge clk_i) disable iff (!reset_n_i)
      $onehot0(~io_sel_i))
      else begin
         $error("more than one i/o chip select active");
         fail_cnt++;
      end

   one_rom_sel: assert property (@(posedge clk_i) disable iff (!reset_n_i)
      $onehot0(~mem_sel_i.rom_cs_n))
      else begin
         $error("more than one rom chip select active");
         fail_cnt++;
      end

   one_ram_bank: assert property (@(posedge clk_i) disable iff (!reset_n_i)
      $onehot0(~mem_sel_i.ram_bank_n))
      else begin
         $error("more than one ram bank select active");
         fail_cnt++;
      end

   rom_ram_apart: assert property (@(posedge clk_i) disable iff (!reset_n_i)
      !((~&mem_sel_i.rom_cs_n) && (~&mem_sel_i.ram_bank_n)))
      else begin
         $error("rom and ram selected in the same cycle");
         fail_cnt++;
      end

   // outputs still hold their reset state on the first edge out of reset
   quiet_after_reset: assert property (@(posedge clk_i)
      $rose(reset_n_i) |-> (&io_sel_i) && (&mem_sel_i) && !nmi_i)
      else begin
         $error("select or nmi active right after reset");
         fail_cnt++;
      end

endmodule

bind pc_glue_top pc_glue_props i_props (
   .clk_i     (clk),
   .reset_n_i (reset_n),
   .io_sel_i  (io_sel_o),
   .mem_sel_i (mem_sel_o),
   .nmi_i     (nmi_o)
);

/* tb_clock_gen.sv */
/*
 * testbench clock, 10 ns period
 * reset low for four rising edges, released on a falling edge
 */
`timescale 1ns/10ps

module tb_clock_gen (
   output logic clk_o,
   output logic reset_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #5 clk_o = ~clk_o;
   end

   initial begin
      reset_n_o = 1'b0;
      repeat (4) @(posedge clk_o);
      @(negedge clk_o);
      reset_n_o = 1'b1;
   end

endmodule

/* pc_glue_tb.sv */
/*
 * testbench for pc_glue_top: random i/o and memory cycles, dma page
 * reads and the nmi path, checked against a cycle model of the board
 * inputs change on the falling edge, outputs are compared there too
 */
`timescale 1ns/10ps
`include "pc_consts.svh"

module pc_glue_tb;

   localparam int N_IO       = 300;
   localparam int N_MEM      = 300;
   localparam int MAX_CYCLES = 2 * (N_IO + N_MEM) + 800;  // stimulus runs ~700 cycles

   typedef struct packed {
      pc_decode_pkg::io_sel_t  io_sel;
      pc_decode_pkg::mem_sel_t mem_sel;
      logic [`PC_ADDR_W-1:0]   addr;
      logic                    nmi;
   } expect_t;

   logic                     clk;
   logic                     reset_n;
   pc_bus_pkg::io_bus_t      io_cycle;
   pc_bus_pkg::mem_bus_t     mem_cycle;
   logic                     aen;
   logic [`PC_DMA_OFS_W-1:0] dma_offset;
   logic [3:0]               dack_n;
   logic                     io_ch_ck_n;
   logic                     enable_io_ck_n;
   pc_decode_pkg::io_sel_t   io_sel;
   pc_decode_pkg::mem_sel_t  mem_sel;
   logic [`PC_ADDR_W-1:0]    bus_addr;
   logic                     nmi;

   int      seed;
   int      cycle_cnt = 0;
   logic    have_exp = 1'b0;
   expect_t exp_q;

   // board model
   logic [`PC_PAGE_W-1:0]   pages_m [`PC_PAGE_N];
   pc_decode_pkg::page_wr_t page_req_m;   // decoded, not yet stored
   pc_decode_pkg::nmi_wr_t  nmi_req_m;
   logic                    mask_m;
   logic                    chk_m;

   tb_clock_gen i_clk_gen (.clk_o(clk), .reset_n_o(reset_n));

   pc_glue_top i_dut (
      .clk              (clk),
      .reset_n          (reset_n),
      .io_cycle_i       (io_cycle),
      .mem_cycle_i      (mem_cycle),
      .aen_i            (aen),
      .dma_offset_i     (dma_offset),
      .dack_n_i         (dack_n),
      .io_ch_ck_n_i     (io_ch_ck_n),
      .enable_io_ck_n_i (enable_io_ck_n),
      .io_sel_o         (io_sel),
      .mem_sel_o        (mem_sel),
      .bus_addr_o       (bus_addr),
      .nmi_o            (nmi)
   );

   // outputs expected after the coming edge, advances the model by one edge
   function automatic expect_t predict_outputs();
      expect_t               e;
      logic                  hit;
      logic                  wr;
      logic [2:0]            grp;
      logic [`PC_PAGE_W-1:0] pg;
      e = {4'hF, 12'hFFF, 20'h0, 1'b0};
      if (!reset_n) begin
         for (int i = 0; i < `PC_PAGE_N; i++) begin
            pages_m[i] = '0;
         end
         page_req_m = '0;
         nmi_req_m  = '0;
         mask_m     = 1'b0;
         chk_m      = 1'b0;
         return e;
      end
      hit = !aen && (io_cycle.xa[9:8] == 2'b00);
      grp = io_cycle.xa[7:5];
      wr  = hit && !io_cycle.iow_n;
      if (hit && (!io_cycle.ior_n || !io_cycle.iow_n)) begin
         case (grp)
            `PC_GRP_DMA:   e.io_sel.dma_cs_n  = 1'b0;
            `PC_GRP_INTR:  e.io_sel.intr_cs_n = 1'b0;
            `PC_GRP_TIMER: e.io_sel.tc_cs_n   = 1'b0;
            `PC_GRP_PPI:   e.io_sel.ppi_cs_n  = 1'b0;
            default:       e.io_sel           = '1;
         endcase
      end
      // words as they stand before the edge
      if (!dack_n[2]) begin
         pg = pages_m[1];            // channel 2, port 0x81
      end else if (!dack_n[3]) begin
         pg = pages_m[2];            // channel 3, port 0x82
      end else begin
         pg = pages_m[3];            // channel 0, 1 or idle, port 0x83
      end
      e.addr = aen ? {pg, dma_offset} : mem_cycle.a;
      if (e.addr[19:16] == `PC_ROM_REGION && !mem_cycle.memr_n) begin
         e.mem_sel.rom_cs_n[e.addr[15:13]] = 1'b0;
      end
      if (e.addr[19:18] == 2'b00 && (!mem_cycle.memr_n || !mem_cycle.memw_n)) begin
         e.mem_sel.ram_bank_n[e.addr[17:16]] = 1'b0;
      end
      if (page_req_m.en) begin
         pages_m[page_req_m.idx] = page_req_m.data;
      end
      if (nmi_req_m.en) begin
         mask_m = nmi_req_m.mask;
      end
      page_req_m = {wr && (grp == `PC_GRP_PAGE), io_cycle.xa[1:0], io_cycle.xd[3:0]};
      nmi_req_m  = {wr && (grp == `PC_GRP_NMI), io_cycle.xd[7]};
      if (!io_ch_ck_n) begin
         chk_m = 1'b1;
      end else if (enable_io_ck_n) begin
         chk_m = 1'b0;
      end
      e.nmi = mask_m && chk_m;
      return e;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] want);
      if (got !== want) begin
         $display("Error: %s is 0x%0h, expected 0x%0h", name, got, want);
         $display(">>> FAIL");
         $fatal(1, "output mismatch");
      end
   endtask

   always @(posedge clk) begin
      exp_q    = predict_outputs();
      have_exp = 1'b1;
   end

   always @(negedge clk) begin
      if (have_exp) begin
         check_value("io_sel_o", 32'(io_sel), 32'(exp_q.io_sel));
         check_value("mem_sel_o", 32'(mem_sel), 32'(exp_q.mem_sel));
         check_value("bus_addr_o", 32'(bus_addr), 32'(exp_q.addr));
         check_value("nmi_o", 32'(nmi), 32'(exp_q.nmi));
      end
      if (i_dut.i_props.fail_cnt != 0) begin
         $display("an output property of the bound checker failed");
         $display(">>> FAIL");
         $fatal(1, "assertion failure");
      end
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("timeout: stimulus still running after %0d cycles", cycle_cnt);
         $display(">>> FAIL");
         $fatal(1, "timeout");
      end
   end

   task automatic drive_idle();
      io_cycle       = {2'b11, 18'h0};
      mem_cycle      = {2'b11, 20'h0};
      aen            = 1'b0;
      dma_offset     = '0;
      dack_n         = 4'hF;
      io_ch_ck_n     = 1'b1;
      enable_io_ck_n = 1'b0;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(negedge clk);
         drive_idle();
      end
   endtask

   task automatic write_port(input logic [9:0] port, input logic [7:0] data);
      @(negedge clk);
      drive_idle();
      io_cycle.iow_n = 1'b0;
      io_cycle.xa    = port;
      io_cycle.xd    = data;
   endtask

   task automatic drive_random_io();
      logic [31:0] r;
      r = $random(seed);
      @(negedge clk);
      drive_idle();
      io_cycle.ior_n = r[15];
      io_cycle.iow_n = r[16];
      io_cycle.xa    = r[9:0];
      if (r[12:11] != 2'b00) begin
         io_cycle.xa[9:8] = 2'b00;      // mostly system board ports
      end
      io_cycle.xd = r[24:17];
      aen         = r[13] & r[14];
   endtask

   task automatic drive_dma(input logic [1:0] ch);
      logic [31:0] r;
      r = $random(seed);
      @(negedge clk);
      drive_idle();
      aen              = 1'b1;
      dack_n[ch]       = 1'b0;
      dma_offset       = r[15:0];
      mem_cycle.a      = {4'h0, r[31:16]};  // cpu address, ignored during dma
      mem_cycle.memr_n = r[20];
      mem_cycle.memw_n = !r[20];
   endtask

   task automatic drive_random_mem();
      logic [31:0] r;
      r = $random(seed);
      @(negedge clk);
      drive_idle();
      mem_cycle.a = r[19:0];
      if (r[22:21] == 2'b00) begin
         mem_cycle.a[19:16] = `PC_ROM_REGION;
      end
      mem_cycle.memr_n = r[23];
      mem_cycle.memw_n = r[24];
   endtask

   task automatic drive_check(input logic ck_n, input logic en_ck_n);
      @(negedge clk);
      drive_idle();
      io_ch_ck_n     = ck_n;
      enable_io_ck_n = en_ck_n;
   endtask

   initial begin
      seed = 81168;
      drive_idle();
      @(posedge reset_n);
      idle_cycles(2);                   // reset state compared by the model
      repeat (N_IO) drive_random_io();
      for (int p = 1; p < 4; p++) begin
         write_port(10'(128 + p), 8'($random(seed)));
      end
      repeat (8) begin
         for (int c = 0; c < 4; c++) begin
            drive_dma(2'(c));           // back to back, no idle between
         end
      end
      repeat (N_MEM) drive_random_mem();
      // check with the mask clear
      write_port(10'h0A0, 8'h00);
      idle_cycles(2);
      drive_check(1'b0, 1'b0);
      drive_check(1'b1, 1'b0);
      check_value("nmi_o", 32'(nmi), 32'h0);
      drive_check(1'b1, 1'b1);
      // mask set, latch holds until enable_io_ck_n goes high
      write_port(10'h0A0, 8'h80);
      idle_cycles(2);
      drive_check(1'b0, 1'b0);
      drive_check(1'b1, 1'b0);
      check_value("nmi_o", 32'(nmi), 32'h1);
      drive_check(1'b1, 1'b0);
      drive_check(1'b1, 1'b0);
      check_value("nmi_o", 32'(nmi), 32'h1);
      drive_check(1'b1, 1'b1);
      drive_check(1'b1, 1'b0);
      check_value("nmi_o", 32'(nmi), 32'h0);
      idle_cycles(3);
      if (i_dut.i_props.fail_cnt == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

/* project.f */
+incdir+.
pc_bus_pkg.sv
pc_decode_pkg.sv
io_port_decoder.sv
dma_page_file.sv
memory_select.sv
nmi_control.sv
pc_glue_top.sv
pc_glue_props.sv
tb_clock_gen.sv
pc_glue_tb.sv

/* run.sh */
#!/bin/sh
# build and run the pc glue testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module pc_glue_tb \
   -f project.f --Mdir obj_dir -o pc_glue_sim

out=$(./obj_dir/pc_glue_sim +verilator+error+limit+100 2>&1) || true
echo "$out"
echo "$out" | grep -qx '>>> PASS'
